//--- rtl/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage
(
	input  logic clk,
	input  logic rst,
	input  logic advance,
	input  lc3b_isa_pkg::word_t instr,
	input  lc3b_isa_pkg::word_t next_pc,
	input  lc3b_pipe_pkg::wb_result_t wb_res,
	output lc3b_pipe_pkg::ex_pkt_t ex_pkt,
	output lc3b_isa_pkg::nzp_t cc
);

	typedef struct packed {
		logic valid;
		lc3b_isa_pkg::word_t next_pc;
		lc3b_isa_pkg::word_t ir;
	} de_reg_t;

	de_reg_t de_q;
	lc3b_pipe_pkg::ctrl_t ctrl;
	lc3b_isa_pkg::reg_idx_t src_b_idx;
	lc3b_isa_pkg::word_t sr1_val;
	lc3b_isa_pkg::word_t sr2_val;

	//////////////////////////////////////////////////////////////////////
	// decode register

	always_ff @(posedge clk)
	begin
		if (advance)
			de_q <= '{valid: 1'b1, next_pc: next_pc, ir: instr};
		if (rst)
			de_q.valid <= 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// control rom

	always_comb
	begin
		ctrl = lc3b_pipe_pkg::ctrl_nop;
		ctrl.opcode = lc3b_isa_pkg::opcode_t'(de_q.ir[15:12]);
		case (de_q.ir[15:12])
			lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and, lc3b_isa_pkg::op_not:
			begin
				ctrl.use_imm = de_q.ir[5];
				ctrl.load_reg = 1'b1;
				ctrl.load_cc = 1'b1;
				if (de_q.ir[15:12] == lc3b_isa_pkg::op_and)
					ctrl.alu_op = lc3b_pipe_pkg::alu_and;
				else if (de_q.ir[15:12] == lc3b_isa_pkg::op_not)
					ctrl.alu_op = lc3b_pipe_pkg::alu_not;
			end
			lc3b_isa_pkg::op_ldr, lc3b_isa_pkg::op_ldb:
			begin
				ctrl.mem_read = 1'b1;
				ctrl.wb_sel = lc3b_pipe_pkg::wb_load;
				ctrl.load_reg = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.byte_access = (de_q.ir[15:12] == lc3b_isa_pkg::op_ldb);
				ctrl.off_sel = ctrl.byte_access ? lc3b_pipe_pkg::off6_byte
					: lc3b_pipe_pkg::off6_word;
			end
			lc3b_isa_pkg::op_str, lc3b_isa_pkg::op_stb:
			begin
				// store data rides through the alu untouched
				ctrl.alu_op = lc3b_pipe_pkg::alu_pass;
				ctrl.sr2_is_dest = 1'b1;
				ctrl.mem_write = 1'b1;
				ctrl.byte_access = (de_q.ir[15:12] == lc3b_isa_pkg::op_stb);
				ctrl.off_sel = ctrl.byte_access ? lc3b_pipe_pkg::off6_byte
					: lc3b_pipe_pkg::off6_word;
			end
			lc3b_isa_pkg::op_lea:
			begin
				// lc-3b lea leaves the condition codes alone
				ctrl.off_sel = lc3b_pipe_pkg::off9_word;
				ctrl.wb_sel = lc3b_pipe_pkg::wb_addr;
				ctrl.load_reg = 1'b1;
			end
			lc3b_isa_pkg::op_br:
			begin
				ctrl.off_sel = lc3b_pipe_pkg::off9_word;
				ctrl.transfer = 1'b1;
			end
			lc3b_isa_pkg::op_jmp:
				ctrl.transfer = 1'b1;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// register read and condition codes

	// stores read their source from the dr field
	assign src_b_idx = ctrl.sr2_is_dest ? de_q.ir[11:9] : de_q.ir[2:0];

	regfile u_regfile
	(
		.clk(clk),
		.load(wb_res.reg_we),
		.dest(wb_res.dest),
		.src_a(de_q.ir[8:6]),
		.src_b(src_b_idx),
		.in(wb_res.data),
		.reg_a(sr1_val),
		.reg_b(sr2_val)
	);

	always_ff @(posedge clk)
	begin
		if (rst)
			cc <= 3'b010;
		else if (wb_res.cc_we)
			cc <= wb_res.cc_new;
	end

	always_comb
	begin
		ex_pkt.valid = de_q.valid;
		ex_pkt.next_pc = de_q.next_pc;
		ex_pkt.ctrl = ctrl;
		ex_pkt.ir = de_q.ir;
		ex_pkt.src_a = sr1_val;
		ex_pkt.src_b = sr2_val;
		ex_pkt.dest = de_q.ir[11:9];
	end

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage
(
	input  logic clk,
	input  logic rst,
	input  logic advance,
	input  lc3b_pipe_pkg::ex_pkt_t ex_pkt,
	output lc3b_pipe_pkg::mem_pkt_t mem_pkt
);

	lc3b_pipe_pkg::ex_pkt_t ex_q;
	lc3b_isa_pkg::word_t operand_b;
	lc3b_isa_pkg::word_t alu_out;
	lc3b_isa_pkg::word_t offset;
	lc3b_isa_pkg::word_t addr_base;

	always_ff @(posedge clk)
	begin
		if (advance)
			ex_q <= ex_pkt;
		if (rst)
			ex_q.valid <= 1'b0;
	end

	// sign extended imm5
	assign operand_b = ex_q.ctrl.use_imm ? {{11{ex_q.ir[4]}}, ex_q.ir[4:0]} : ex_q.src_b;

	always_comb
	begin
		case (ex_q.ctrl.alu_op)
			lc3b_pipe_pkg::alu_add: alu_out = ex_q.src_a + operand_b;
			lc3b_pipe_pkg::alu_and: alu_out = ex_q.src_a & operand_b;
			lc3b_pipe_pkg::alu_not: alu_out = ~ex_q.src_a;
			default: alu_out = operand_b;
		endcase
	end

	always_comb
	begin
		case (ex_q.ctrl.off_sel)
			lc3b_pipe_pkg::off6_word: offset = {{9{ex_q.ir[5]}}, ex_q.ir[5:0], 1'b0};
			lc3b_pipe_pkg::off6_byte: offset = {{10{ex_q.ir[5]}}, ex_q.ir[5:0]};
			lc3b_pipe_pkg::off9_word: offset = {{6{ex_q.ir[8]}}, ex_q.ir[8:0], 1'b0};
			default: offset = '0;
		endcase
	end

	// pc relative for br and lea, base register otherwise (jmp adds zero)
	assign addr_base = (ex_q.ctrl.off_sel == lc3b_pipe_pkg::off9_word) ? ex_q.next_pc
		: ex_q.src_a;

	always_comb
	begin
		mem_pkt.valid = ex_q.valid;
		mem_pkt.next_pc = ex_q.next_pc;
		mem_pkt.ctrl = ex_q.ctrl;
		mem_pkt.ir = ex_q.ir;
		mem_pkt.alu = alu_out;
		mem_pkt.addr = addr_base + offset;
		mem_pkt.dest = ex_q.dest;
	end

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage
(
	input  logic clk,
	input  logic rst,
	input  logic mem_resp_a,
	input  logic mem_resp_b,
	input  logic data_busy,
	input  lc3b_pipe_pkg::wb_result_t wb_res,
	output logic advance,
	output logic mem_read_a,
	output lc3b_isa_pkg::word_t pc,
	output lc3b_isa_pkg::word_t next_pc
);

	lc3b_isa_pkg::word_t pc_in;

	// whole pipe moves only when both ports are done
	assign advance = mem_resp_a & (mem_resp_b | ~data_busy);

	assign next_pc = pc + 16'd2;

	// taken transfer from write back overrides sequential fetch
	assign pc_in = wb_res.redirect ? wb_res.target : next_pc;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc <= lc3b_isa_pkg::reset_pc;
			mem_read_a <= 1'b0;
		end
		else
		begin
			// instruction port is always requesting once out of reset
			mem_read_a <= 1'b1;
			if (advance)
				pc <= pc_in;
		end
	end

endmodule

`default_nettype wire

//--- rtl/lc3b_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module lc3b_datapath
(
	input  logic clk,
	input  logic rst,
	input  logic mem_resp_a,
	input  logic mem_resp_b,
	input  lc3b_isa_pkg::word_t mem_rdata_a,
	input  lc3b_isa_pkg::word_t mem_rdata_b,
	output logic mem_read_a,
	output logic mem_write_a,
	output logic mem_read_b,
	output logic mem_write_b,
	output logic [1:0] mem_wmask_a,
	output logic [1:0] mem_wmask_b,
	output lc3b_isa_pkg::word_t mem_address_a,
	output lc3b_isa_pkg::word_t mem_wdata_a,
	output lc3b_isa_pkg::word_t mem_address_b,
	output lc3b_isa_pkg::word_t mem_wdata_b
);

	logic advance;
	logic data_busy;
	lc3b_isa_pkg::word_t next_pc;
	lc3b_isa_pkg::nzp_t cc;
	lc3b_pipe_pkg::ex_pkt_t ex_pkt;
	lc3b_pipe_pkg::mem_pkt_t mem_pkt;
	lc3b_pipe_pkg::wb_pkt_t wb_pkt;
	lc3b_pipe_pkg::wb_result_t wb_res;

	// instruction port never writes
	assign mem_write_a = 1'b0;
	assign mem_wmask_a = 2'b11;
	assign mem_wdata_a = '0;

	//////////////////////////////////////////////////////////////////////
	// stages

	fetch_stage u_fetch
	(
		.clk(clk),
		.rst(rst),
		.mem_resp_a(mem_resp_a),
		.mem_resp_b(mem_resp_b),
		.data_busy(data_busy),
		.wb_res(wb_res),
		.advance(advance),
		.mem_read_a(mem_read_a),
		.pc(mem_address_a),
		.next_pc(next_pc)
	);

	decode_stage u_decode
	(
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.instr(mem_rdata_a),
		.next_pc(next_pc),
		.wb_res(wb_res),
		.ex_pkt(ex_pkt),
		.cc(cc)
	);

	execute_stage u_execute
	(
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.ex_pkt(ex_pkt),
		.mem_pkt(mem_pkt)
	);

	memory_stage u_memory
	(
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.mem_pkt(mem_pkt),
		.mem_rdata_b(mem_rdata_b),
		.wb_pkt(wb_pkt),
		.data_busy(data_busy),
		.mem_read_b(mem_read_b),
		.mem_write_b(mem_write_b),
		.mem_wmask_b(mem_wmask_b),
		.mem_address_b(mem_address_b),
		.mem_wdata_b(mem_wdata_b)
	);

	writeback_stage u_writeback
	(
		.clk(clk),
		.rst(rst),
		.advance(advance),
		.wb_pkt(wb_pkt),
		.cc(cc),
		.wb_res(wb_res)
	);

endmodule

`default_nettype wire

//--- rtl/lc3b_isa_pkg.sv
`default_nettype none

package lc3b_isa_pkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0] reg_idx_t;

	// n in bit 2, z in bit 1, p in bit 0
	typedef logic [2:0] nzp_t;

	localparam logic [3:0] op_br  = 4'b0000;
	localparam logic [3:0] op_add = 4'b0001;
	localparam logic [3:0] op_ldb = 4'b0010;
	localparam logic [3:0] op_stb = 4'b0011;
	localparam logic [3:0] op_and = 4'b0101;
	localparam logic [3:0] op_ldr = 4'b0110;
	localparam logic [3:0] op_str = 4'b0111;
	localparam logic [3:0] op_not = 4'b1001;
	localparam logic [3:0] op_jmp = 4'b1100;
	localparam logic [3:0] op_lea = 4'b1110;

	// only the implemented subset gets a name
	typedef enum logic [3:0] {
		opc_br  = op_br,
		opc_add = op_add,
		opc_ldb = op_ldb,
		opc_stb = op_stb,
		opc_and = op_and,
		opc_ldr = op_ldr,
		opc_str = op_str,
		opc_not = op_not,
		opc_jmp = op_jmp,
		opc_lea = op_lea
	} opcode_t;

	// first fetch address out of reset
	localparam word_t reset_pc = 16'h0000;

endpackage

`default_nettype wire

//--- rtl/lc3b_pipe_pkg.sv
`default_nettype none

package lc3b_pipe_pkg;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} alu_op_t;

	typedef enum logic [1:0] {
		wb_alu,
		wb_load,
		wb_addr,
		wb_pc
	} wb_sel_t;

	// off9 also picks next pc as the adder base
	typedef enum logic [1:0] {
		off_none,
		off6_word,
		off6_byte,
		off9_word
	} off_sel_t;

	typedef struct packed {
		lc3b_isa_pkg::opcode_t opcode;
		alu_op_t alu_op;
		logic use_imm;
		logic sr2_is_dest;
		off_sel_t off_sel;
		logic mem_read;
		logic mem_write;
		logic byte_access;
		wb_sel_t wb_sel;
		logic load_reg;
		logic load_cc;
		logic transfer;
	} ctrl_t;

	// decoded form of anything outside the subset
	localparam ctrl_t ctrl_nop = '0;

	typedef struct packed {
		logic valid;
		lc3b_isa_pkg::word_t next_pc;
		ctrl_t ctrl;
		lc3b_isa_pkg::word_t ir;
		lc3b_isa_pkg::word_t src_a;
		lc3b_isa_pkg::word_t src_b;
		lc3b_isa_pkg::reg_idx_t dest;
	} ex_pkt_t;

	typedef struct packed {
		logic valid;
		lc3b_isa_pkg::word_t next_pc;
		ctrl_t ctrl;
		lc3b_isa_pkg::word_t ir;
		lc3b_isa_pkg::word_t alu;
		lc3b_isa_pkg::word_t addr;
		lc3b_isa_pkg::reg_idx_t dest;
	} mem_pkt_t;

	typedef struct packed {
		logic valid;
		lc3b_isa_pkg::word_t next_pc;
		ctrl_t ctrl;
		lc3b_isa_pkg::word_t ir;
		lc3b_isa_pkg::word_t alu;
		lc3b_isa_pkg::word_t addr;
		lc3b_isa_pkg::reg_idx_t dest;
		lc3b_isa_pkg::word_t rdata;
	} wb_pkt_t;

	typedef struct packed {
		logic reg_we;
		lc3b_isa_pkg::reg_idx_t dest;
		lc3b_isa_pkg::word_t data;
		logic cc_we;
		lc3b_isa_pkg::nzp_t cc_new;
		logic redirect;
		lc3b_isa_pkg::word_t target;
	} wb_result_t;

endpackage

`default_nettype wire

//--- rtl/memory_stage.sv
`timescale 1ns/100ps
`default_nettype none

module memory_stage
(
	input  logic clk,
	input  logic rst,
	input  logic advance,
	input  lc3b_pipe_pkg::mem_pkt_t mem_pkt,
	input  lc3b_isa_pkg::word_t mem_rdata_b,
	output lc3b_pipe_pkg::wb_pkt_t wb_pkt,
	output logic data_busy,
	output logic mem_read_b,
	output logic mem_write_b,
	output logic [1:0] mem_wmask_b,
	output lc3b_isa_pkg::word_t mem_address_b,
	output lc3b_isa_pkg::word_t mem_wdata_b
);

	lc3b_pipe_pkg::mem_pkt_t mem_q;

	always_ff @(posedge clk)
	begin
		if (advance)
			mem_q <= mem_pkt;
		if (rst)
			mem_q.valid <= 1'b0;
	end

	assign mem_read_b = mem_q.valid & mem_q.ctrl.mem_read;
	assign mem_write_b = mem_q.valid & mem_q.ctrl.mem_write;
	assign data_busy = mem_read_b | mem_write_b;

	assign mem_address_b = mem_q.addr;

	// byte stores copy the low byte to both lanes, mask picks the lane
	assign mem_wdata_b = mem_q.ctrl.byte_access ? {2{mem_q.alu[7:0]}} : mem_q.alu;
	assign mem_wmask_b = mem_q.ctrl.byte_access ? {mem_q.addr[0], ~mem_q.addr[0]} : 2'b11;

	always_comb
	begin
		wb_pkt.valid = mem_q.valid;
		wb_pkt.next_pc = mem_q.next_pc;
		wb_pkt.ctrl = mem_q.ctrl;
		wb_pkt.ir = mem_q.ir;
		wb_pkt.alu = mem_q.alu;
		wb_pkt.addr = mem_q.addr;
		wb_pkt.dest = mem_q.dest;
		wb_pkt.rdata = mem_rdata_b;
	end

endmodule

`default_nettype wire

//--- rtl/regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile
(
	input  logic clk,
	input  logic load,
	input  lc3b_isa_pkg::reg_idx_t dest,
	input  lc3b_isa_pkg::reg_idx_t src_a,
	input  lc3b_isa_pkg::reg_idx_t src_b,
	input  lc3b_isa_pkg::word_t in,
	output lc3b_isa_pkg::word_t reg_a,
	output lc3b_isa_pkg::word_t reg_b
);

	lc3b_isa_pkg::word_t regs [0:7];

	always_ff @(posedge clk)
	begin
		if (load)
			regs[dest] <= in;
	end

	// write before read in the same cycle
	assign reg_a = (load && (dest == src_a)) ? in : regs[src_a];
	assign reg_b = (load && (dest == src_b)) ? in : regs[src_b];

endmodule

`default_nettype wire

//--- rtl/writeback_stage.sv
`timescale 1ns/100ps
`default_nettype none

module writeback_stage
(
	input  logic clk,
	input  logic rst,
	input  logic advance,
	input  lc3b_pipe_pkg::wb_pkt_t wb_pkt,
	input  lc3b_isa_pkg::nzp_t cc,
	output lc3b_pipe_pkg::wb_result_t wb_res
);

	lc3b_pipe_pkg::wb_pkt_t wb_q;
	logic [7:0] load_byte;
	lc3b_isa_pkg::word_t load_val;
	lc3b_isa_pkg::word_t result;
	lc3b_isa_pkg::nzp_t new_cc;
	logic cond_met;
	logic is_jmp;

	always_ff @(posedge clk)
	begin
		if (advance)
			wb_q <= wb_pkt;
		if (rst)
			wb_q.valid <= 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// result select

	// odd address means the high byte
	assign load_byte = wb_q.addr[0] ? wb_q.rdata[15:8] : wb_q.rdata[7:0];
	assign load_val = wb_q.ctrl.byte_access ? {{8{load_byte[7]}}, load_byte} : wb_q.rdata;

	always_comb
	begin
		case (wb_q.ctrl.wb_sel)
			lc3b_pipe_pkg::wb_load: result = load_val;
			lc3b_pipe_pkg::wb_addr: result = wb_q.addr;
			lc3b_pipe_pkg::wb_pc: result = wb_q.next_pc;
			default: result = wb_q.alu;
		endcase
	end

	assign new_cc = result[15] ? 3'b100 : ((result == '0) ? 3'b010 : 3'b001);

	//////////////////////////////////////////////////////////////////////
	// branch resolution

	assign cond_met = |(wb_q.ir[11:9] & cc);
	assign is_jmp = (wb_q.ctrl.opcode == lc3b_isa_pkg::opc_jmp);

	always_comb
	begin
		wb_res.reg_we = wb_q.valid & advance & wb_q.ctrl.load_reg;
		wb_res.dest = wb_q.dest;
		wb_res.data = result;
		wb_res.cc_we = wb_q.valid & advance & wb_q.ctrl.load_cc;
		wb_res.cc_new = new_cc;
		wb_res.redirect = wb_q.valid & wb_q.ctrl.transfer & (is_jmp | cond_met);
		wb_res.target = wb_q.addr;
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the lc3b datapath simulation with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_lc3b_datapath \
	-f vlog.f -o sim_lc3b > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_lc3b > sim.log 2>&1
grep -q "^RESULT: PASS$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

//--- testbench/lc3b_datapath_chk.sv
`timescale 1ns/100ps
`default_nettype none

module lc3b_datapath_chk
(
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic advance,
	input  wire logic redirect,
	input  wire logic [15:0] target,
	input  wire logic mem_read_a,
	input  wire logic mem_write_a,
	input  wire logic mem_resp_a,
	input  wire logic [15:0] mem_address_a,
	input  wire logic [15:0] mem_wdata_a,
	input  wire logic [1:0] mem_wmask_a,
	input  wire logic mem_read_b,
	input  wire logic mem_write_b,
	input  wire logic mem_resp_b,
	input  wire logic [15:0] mem_address_b,
	input  wire logic [15:0] mem_wdata_b,
	input  wire logic [1:0] mem_wmask_b
);

	// first address at or above this is only stored by skipped instructions
	localparam logic [15:0] skipped_base = 16'h023c;

	int fail_cnt = 0;

	//////////////////////////////////////////////////////////////////////
	// reset and port protocol

	a_reset_quiet: assert property (@(posedge clk)
		$fell(rst) |-> (!mem_read_b && !mem_write_b
			&& mem_address_a == lc3b_isa_pkg::reset_pc))
		else
		begin
			fail_cnt = fail_cnt + 1;
			$error("data port active or wrong fetch address after reset");
		end

	// instruction port is read only, full word
	a_port_a_read_only: assert property (@(posedge clk) disable iff (rst)
		(!mem_write_a && mem_wmask_a == 2'b11))
		else
		begin
			fail_cnt = fail_cnt + 1;
			$error("instruction port asked for a write or a partial mask");
		end

	a_port_a_stable: assert property (@(posedge clk) disable iff (rst)
		(mem_read_a && !mem_resp_a)
		|=> ($stable(mem_address_a) && $stable(mem_wdata_a) && $stable(mem_wmask_a)))
		else
		begin
			fail_cnt = fail_cnt + 1;
			$error("instruction request moved while waiting");
		end

	a_port_b_stable: assert property (@(posedge clk) disable iff (rst)
		((mem_read_b || mem_write_b) && !mem_resp_b)
		|=> ($stable(mem_address_b) && $stable(mem_wdata_b) && $stable(mem_wmask_b)))
		else
		begin
			fail_cnt = fail_cnt + 1;
			$error("data request moved while waiting");
		end

	//////////////////////////////////////////////////////////////////////
	// fetch address sequence

	a_pc_hold: assert property (@(posedge clk) disable iff (rst)
		!advance |=> $stable(mem_address_a))
		else
		begin
			fail_cnt = fail_cnt + 1;
			$error("fetch address changed without advance");
		end

	// plus 2, or the redirect target seen in the advance cycle
	a_pc_step: assert property (@(posedge clk) disable iff (rst)
		advance |=> ((mem_address_a == $past(mem_address_a) + 16'd2)
			|| ($past(redirect) && mem_address_a == $past(target))))
		else
		begin
			fail_cnt = fail_cnt + 1;
			$error("fetch address is neither sequential nor a redirect target");
		end

	a_no_skipped_store: assert property (@(posedge clk) disable iff (rst)
		mem_write_b |-> (mem_address_b < skipped_base))
		else
		begin
			fail_cnt = fail_cnt + 1;
			$error("store from a skipped path reached the data port");
		end

endmodule

`default_nettype wire

//--- testbench/tb_lc3b_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module tb_lc3b_datapath;

	logic clk;
	logic rst;
	logic mem_resp_a;
	logic mem_resp_b;
	logic [15:0] mem_rdata_a;
	logic [15:0] mem_rdata_b;
	logic mem_read_a;
	logic mem_write_a;
	logic mem_read_b;
	logic mem_write_b;
	logic [1:0] mem_wmask_a;
	logic [1:0] mem_wmask_b;
	logic [15:0] mem_address_a;
	logic [15:0] mem_wdata_a;
	logic [15:0] mem_address_b;
	logic [15:0] mem_wdata_b;

	logic [15:0] mem [0:1023];
	logic [15:0] exp_addr [0:15];
	logic [15:0] exp_data [0:15];
	logic [1:0] exp_mask [0:15];
	int n_exp;
	int store_cnt;
	int errors;
	int wait_cnt;
	int delay;
	int cycles;

	lc3b_datapath DUT
	(
		.clk(clk), .rst(rst),
		.mem_resp_a(mem_resp_a), .mem_resp_b(mem_resp_b),
		.mem_rdata_a(mem_rdata_a), .mem_rdata_b(mem_rdata_b),
		.mem_read_a(mem_read_a), .mem_write_a(mem_write_a),
		.mem_read_b(mem_read_b), .mem_write_b(mem_write_b),
		.mem_wmask_a(mem_wmask_a), .mem_wmask_b(mem_wmask_b),
		.mem_address_a(mem_address_a), .mem_wdata_a(mem_wdata_a),
		.mem_address_b(mem_address_b), .mem_wdata_b(mem_wdata_b)
	);

	bind lc3b_datapath lc3b_datapath_chk chk
	(
		.clk(clk), .rst(rst), .advance(advance),
		.redirect(wb_res.redirect), .target(wb_res.target),
		.mem_read_a(mem_read_a), .mem_resp_a(mem_resp_a), .mem_address_a(mem_address_a),
		.mem_write_a(mem_write_a), .mem_wmask_a(mem_wmask_a), .mem_wdata_a(mem_wdata_a),
		.mem_read_b(mem_read_b), .mem_write_b(mem_write_b), .mem_resp_b(mem_resp_b),
		.mem_address_b(mem_address_b), .mem_wdata_b(mem_wdata_b), .mem_wmask_b(mem_wmask_b)
	);

	//////////////////////////////////////////////////////////////////////
	// assembler helpers

	function automatic logic [15:0] enc_imm(input logic [3:0] op, input logic [2:0] dr,
		input logic [2:0] sr, input logic [4:0] imm);
		return {op, dr, sr, 1'b1, imm};
	endfunction

	function automatic logic [15:0] enc_reg(input logic [3:0] op, input logic [2:0] dr,
		input logic [2:0] sr1, input logic [2:0] sr2);
		return {op, dr, sr1, 3'b000, sr2};
	endfunction

	// ldr, str, ldb, stb and jmp share this shape
	function automatic logic [15:0] enc_mem(input logic [3:0] op, input logic [2:0] r,
		input logic [2:0] base, input logic [5:0] off6);
		return {op, r, base, off6};
	endfunction

	// br (nzp) and lea (dr)
	function automatic logic [15:0] enc_pc9(input logic [3:0] op, input logic [2:0] f,
		input logic [8:0] off9);
		return {op, f, off9};
	endfunction

	// data region pattern, every word index bit matters
	function automatic logic [15:0] fill_word(input logic [9:0] i);
		return {~i[7:0], i[9:8], 6'h25};
	endfunction

	task automatic add_expected(input logic [15:0] a, input logic [15:0] d, input logic [1:0] m);
		exp_addr[n_exp] = a;
		exp_data[n_exp] = d;
		exp_mask[n_exp] = m;
		n_exp = n_exp + 1;
	endtask

	task automatic check_store(input logic [15:0] a, input logic [15:0] d, input logic [1:0] m);
		if (store_cnt >= n_exp)
		begin
			$display("unexpected extra store to %h at %0t", a, $time);
			errors = errors + 1;
		end
		else
		begin
			if (a !== exp_addr[store_cnt])
			begin
				$display("** Error at %0t: mem_address_b = %h, expected %h", $time, a,
					exp_addr[store_cnt]);
				errors = errors + 1;
			end
			if (d !== exp_data[store_cnt])
			begin
				$display("** Error at %0t: mem_wdata_b = %h, expected %h", $time, d,
					exp_data[store_cnt]);
				errors = errors + 1;
			end
			if (m !== exp_mask[store_cnt])
			begin
				$display("** Error at %0t: mem_wmask_b = %b, expected %b", $time, m,
					exp_mask[store_cnt]);
				errors = errors + 1;
			end
		end
		store_cnt = store_cnt + 1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// program image and expected stores

	task automatic load_program();
		logic [15:0] r0;
		logic [15:0] r1;
		logic [15:0] ld_byte;
		for (int i = 0; i < 1024; i++)
			mem[i] = (i < 256) ? 16'h0000 : fill_word(10'(i));
		// gaps of nops come from the zero fill
		mem[0] = enc_pc9(lc3b_isa_pkg::op_lea, 3'd6, 9'd255);
		mem[1] = enc_imm(lc3b_isa_pkg::op_and, 3'd0, 3'd0, 5'd0);
		mem[2] = enc_imm(lc3b_isa_pkg::op_and, 3'd1, 3'd1, 5'd0);
		mem[4] = enc_imm(lc3b_isa_pkg::op_add, 3'd0, 3'd0, 5'd7);
		mem[5] = enc_imm(lc3b_isa_pkg::op_add, 3'd1, 3'd1, 5'h1d);
		mem[8] = enc_reg(lc3b_isa_pkg::op_add, 3'd2, 3'd0, 3'd1);
		mem[9] = enc_imm(lc3b_isa_pkg::op_and, 3'd3, 3'd0, 5'd5);
		mem[10] = enc_imm(lc3b_isa_pkg::op_not, 3'd4, 3'd1, 5'h1f);
		mem[12] = enc_mem(lc3b_isa_pkg::op_str, 3'd2, 3'd6, 6'd0);
		mem[13] = enc_mem(lc3b_isa_pkg::op_str, 3'd3, 3'd6, 6'd1);
		mem[14] = enc_mem(lc3b_isa_pkg::op_str, 3'd4, 3'd6, 6'd2);
		mem[15] = enc_reg(lc3b_isa_pkg::op_and, 3'd5, 3'd0, 3'd1);
		mem[18] = enc_mem(lc3b_isa_pkg::op_str, 3'd5, 3'd6, 6'd3);
		mem[19] = enc_mem(lc3b_isa_pkg::op_stb, 3'd0, 3'd6, 6'd8);
		mem[20] = enc_mem(lc3b_isa_pkg::op_stb, 3'd1, 3'd6, 6'd9);
		mem[21] = enc_mem(lc3b_isa_pkg::op_ldb, 3'd7, 3'd6, 6'd13);
		mem[22] = enc_mem(lc3b_isa_pkg::op_ldr, 3'd5, 3'd6, 6'd1);
		mem[24] = enc_mem(lc3b_isa_pkg::op_str, 3'd7, 3'd6, 6'd8);
		mem[25] = enc_imm(lc3b_isa_pkg::op_add, 3'd5, 3'd5, 5'd1);
		mem[28] = enc_mem(lc3b_isa_pkg::op_str, 3'd5, 3'd6, 6'd9);
		mem[29] = enc_imm(lc3b_isa_pkg::op_add, 3'd0, 3'd0, 5'd0);
		// brn not taken, brp taken to word 40
		mem[30] = enc_pc9(lc3b_isa_pkg::op_br, 3'b100, 9'd5);
		mem[31] = enc_pc9(lc3b_isa_pkg::op_br, 3'b001, 9'd8);
		mem[32] = enc_mem(lc3b_isa_pkg::op_str, 3'd0, 3'd6, 6'd10);
		mem[36] = enc_mem(lc3b_isa_pkg::op_str, 3'd1, 3'd6, 6'd31);
		mem[40] = enc_pc9(lc3b_isa_pkg::op_lea, 3'd2, 9'd11);
		mem[43] = enc_mem(lc3b_isa_pkg::op_jmp, 3'd0, 3'd2, 6'd0);
		mem[44] = enc_mem(lc3b_isa_pkg::op_str, 3'd3, 3'd6, 6'd11);
		mem[49] = enc_mem(lc3b_isa_pkg::op_str, 3'd1, 3'd6, 6'd30);
		mem[52] = enc_mem(lc3b_isa_pkg::op_str, 3'd4, 3'd6, 6'd12);
		mem[53] = enc_pc9(lc3b_isa_pkg::op_br, 3'b111, 9'h1ff);

		r0 = 16'd7;
		r1 = 16'hfffd;
		ld_byte = fill_word(10'h106) >> 8;
		n_exp = 0;
		add_expected(16'h0200, r0 + r1, 2'b11);
		add_expected(16'h0202, r0 & 16'd5, 2'b11);
		add_expected(16'h0204, ~r1, 2'b11);
		add_expected(16'h0206, r0 & r1, 2'b11);
		add_expected(16'h0208, {2{r0[7:0]}}, 2'b01);
		add_expected(16'h0209, {2{r1[7:0]}}, 2'b10);
		add_expected(16'h0210, {{8{ld_byte[7]}}, ld_byte[7:0]}, 2'b11);
		add_expected(16'h0212, (r0 & 16'd5) + 16'd1, 2'b11);
		add_expected(16'h0214, r0, 2'b11);
		add_expected(16'h0216, r0 & 16'd5, 2'b11);
		add_expected(16'h0218, ~r1, 2'b11);
	endtask

	//////////////////////////////////////////////////////////////////////
	// memory model, one shared random latency for both ports

	always @(negedge clk)
	begin
		mem_resp_a <= 1'b0;
		mem_resp_b <= 1'b0;
		if (!rst && mem_read_a)
		begin
			if (wait_cnt >= delay)
			begin
				mem_resp_a <= 1'b1;
				mem_rdata_a <= mem[mem_address_a[10:1]];
				if (mem_read_b)
				begin
					mem_resp_b <= 1'b1;
					mem_rdata_b <= mem[mem_address_b[10:1]];
				end
				if (mem_write_b)
				begin
					mem_resp_b <= 1'b1;
					if (mem_wmask_b[0])
						mem[mem_address_b[10:1]][7:0] = mem_wdata_b[7:0];
					if (mem_wmask_b[1])
						mem[mem_address_b[10:1]][15:8] = mem_wdata_b[15:8];
					check_store(mem_address_b, mem_wdata_b, mem_wmask_b);
				end
				wait_cnt = 0;
				delay = int'($urandom % 4);
			end
			else
				wait_cnt = wait_cnt + 1;
		end
	end

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial
	begin
		void'($urandom(32'h4a3849c7));
		rst = 1'b1;
		mem_resp_a = 1'b0;
		mem_resp_b = 1'b0;
		mem_rdata_a = '0;
		mem_rdata_b = '0;
		errors = 0;
		store_cnt = 0;
		wait_cnt = 0;
		delay = 0;
		load_program();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		cycles = 0;
		while (store_cnt < n_exp && cycles < 3000)
		begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		if (store_cnt < n_exp)
		begin
			$display("timeout: only %0d of %0d stores seen", store_cnt, n_exp);
			errors = errors + 1;
		end

		// program is done once the final self loop is fetched
		cycles = 0;
		while (!(mem_address_a == 16'd106 && mem_resp_a) && cycles < 500)
		begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		if (cycles >= 500)
		begin
			$display("timeout: final loop never fetched");
			errors = errors + 1;
		end

		$display("stores seen: %0d of %0d, errors: %0d, assertion failures: %0d",
			store_cnt, n_exp, errors, DUT.chk.fail_cnt);
		if (errors == 0 && DUT.chk.fail_cnt == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
rtl/lc3b_isa_pkg.sv
rtl/lc3b_pipe_pkg.sv
rtl/regfile.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/writeback_stage.sv
rtl/lc3b_datapath.sv
testbench/lc3b_datapath_chk.sv
testbench/tb_lc3b_datapath.sv
